// File: bench/iCacheTb.sv
`timescale 1ns/1ps

module iCacheTb;
    import icachePkg::*;

    localparam int numFetches = 2000;
    localparam int timeoutCycles = numFetches * 12;

    typedef enum {phRestart, phLookup, phRefill} phaseT;

    logic clk;
    logic rst;
    logic [addrBits-1:0] pc;
    logic stall;
    logic memReqValid;
    logic [addrBits-1:0] memReqAddr;
    logic memRespValid;
    cacheLineT memRespLine;
    logic [addrBits-1:0] outPc;
    logic inst0Valid;
    logic [addrBits-1:0] inst0;
    logic inst1Valid;
    logic [addrBits-1:0] inst1;

    // reference cache state
    logic [tagBits-1:0] refTag [numSets][numWays];
    logic [numWays-1:0] refValid [numSets];
    logic [2:0] refAge [numSets];

    logic [addrBits-1:0] fetchAddr [numFetches];
    int srcIdx;
    int pairsDone;
    int cycleCount;
    int respDelay;
    phaseT phase;
    logic [addrBits-1:0] modelPc;
    logic [addrBits-1:0] respAddr;
    logic accepted;
    logic respBusy;

    iCacheTop u_iCacheTop (
        .clk          (clk),
        .rst          (rst),
        .pc           (pc),
        .stall        (stall),
        .memReqValid  (memReqValid),
        .memReqAddr   (memReqAddr),
        .memRespValid (memRespValid),
        .memRespLine  (memRespLine),
        .outPc        (outPc),
        .inst0Valid   (inst0Valid),
        .inst0        (inst0),
        .inst1Valid   (inst1Valid),
        .inst1        (inst1)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < timeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the run did not finish within %0d cycles", timeoutCycles);
        $display("Done: errors found");
        $fatal(1, "simulation timed out");
    end

    // every memory word is a scramble of its own byte address
    function automatic logic [addrBits-1:0] memWord(input logic [addrBits-1:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    function automatic cacheLineT memLine(input logic [addrBits-1:0] base);
        cacheLineT line;
        for (int i = 0; i < 4; i++) begin
            line.words[i] = memWord(base + 32'(4 * i));
        end
        return line;
    endfunction

    function automatic logic [2:0] agedAfter(input logic [2:0] age, input int way);
        logic [2:0] upd;
        upd = age;
        upd[2] = (way < 2);
        if (way < 2) begin
            upd[0] = (way == 0);
        end else begin
            upd[1] = (way == 2);
        end
        return upd;
    endfunction

    function automatic int pickVictim(input int set);
        int victim;
        victim = -1;
        for (int w = 0; w < numWays; w++) begin
            if (victim < 0 && !refValid[set][w]) begin
                victim = w;
            end
        end
        if (victim < 0) begin
            victim = refAge[set][2] ? (refAge[set][1] ? 3 : 2) : (refAge[set][0] ? 1 : 0);
        end
        return victim;
    endfunction

    function automatic int findWay(input logic [addrBits-1:0] addr);
        int found;
        found = -1;
        for (int w = 0; w < numWays; w++) begin
            if (found < 0 && refValid[addr[9:4]][w] && refTag[addr[9:4]][w] == addr[31:10]) begin
                found = w;
            end
        end
        return found;
    endfunction

    // total of failed protocol assertions in the bound checker
    function automatic int protocolFailures();
        return u_iCacheTop.u_iCacheTopSva.reqStallFails
            + u_iCacheTop.u_iCacheTopSva.addrStableFails
            + u_iCacheTop.u_iCacheTopSva.resetValidFails
            + u_iCacheTop.u_iCacheTopSva.earlyPairFails;
    endfunction

    task automatic checkValue(input logic [31:0] got, input logic [31:0] expected,
                              input string what);
        if (got !== expected) begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, expected);
            $display("Done: errors found");
            $fatal(1, "check failed");
        end
    endtask

    task automatic expectPair(input logic [addrBits-1:0] addr);
        logic [addrBits-1:0] pairBase;
        pairBase = {addr[31:3], 3'b000};
        checkValue(outPc, pairBase, "outPc");
        checkValue(inst0Valid, !addr[2], "inst0Valid");
        checkValue(inst1Valid, 1, "inst1Valid");
        if (!addr[2]) begin
            checkValue(inst0, memWord(pairBase), "inst0");
        end
        checkValue(inst1, memWord(pairBase + 32'd4), "inst1");
    endtask

    // one cycle of the reference model with outputs sampled just after the falling edge
    task automatic stepModel();
        int way;
        int set;
        logic [addrBits-1:0] lineBase;
        set = int'(modelPc[9:4]);
        lineBase = {modelPc[31:4], 4'h0};
        accepted = 1'b0;
        checkValue(protocolFailures(), 0, "protocol assertion failure count");
        case (phase)
            phRestart: begin
                checkValue(stall, 0, "stall in restart");
                checkValue(memReqValid, 0, "memReqValid in restart");
                checkValue({inst0Valid, inst1Valid}, 0, "valids in restart");
                accepted = 1'b1;
                phase = phLookup;
            end
            phLookup: begin
                way = findWay(modelPc);
                if (way >= 0) begin
                    checkValue(stall, 0, "stall on hit");
                    checkValue(memReqValid, 0, "memReqValid on hit");
                    expectPair(modelPc);
                    refAge[set] = agedAfter(refAge[set], way);
                    pairsDone++;
                    accepted = 1'b1;
                end else begin
                    checkValue(stall, 1, "stall on miss");
                    checkValue(memReqValid, 1, "memReqValid on miss");
                    checkValue(memReqAddr, lineBase, "memReqAddr on miss");
                    checkValue({inst0Valid, inst1Valid}, 0, "valids on miss");
                    phase = phRefill;
                end
            end
            default: begin
                checkValue(stall, 1, "stall during refill");
                checkValue(memReqValid, 1, "memReqValid during refill");
                checkValue(memReqAddr, lineBase, "memReqAddr during refill");
                if (memRespValid) begin
                    expectPair(modelPc);
                    way = pickVictim(set);
                    refTag[set][way] = modelPc[31:10];
                    refValid[set][way] = 1'b1;
                    refAge[set] = agedAfter(refAge[set], way);
                    pairsDone++;
                    phase = phRestart;
                end else begin
                    checkValue({inst0Valid, inst1Valid}, 0, "valids while waiting");
                end
            end
        endcase
        if (accepted) begin
            modelPc = pc;
        end
        // memory side picks up a new request
        if (memReqValid && !respBusy) begin
            respBusy = 1'b1;
            respAddr = memReqAddr;
            respDelay = 1 + int'($urandom % 6);
        end
    endtask

    task automatic driveInputs();
        if (memRespValid) begin
            memRespValid = 1'b0;
            respBusy = 1'b0;
        end else if (respBusy) begin
            respDelay--;
            if (respDelay == 0) begin
                memRespValid = 1'b1;
                memRespLine = memLine(respAddr);
            end
        end
        if (accepted && srcIdx < numFetches - 1) begin
            srcIdx++;
            pc = fetchAddr[srcIdx];
        end
    endtask

    // sequential pairs mixed with jumps over 8 tags so sets overflow
    task automatic makeFetches();
        logic [addrBits-1:0] addr;
        logic [tagBits-1:0] jumpTag;
        addr = '0;
        for (int i = 0; i < numFetches; i++) begin
            if (i == 0 || $urandom % 4 == 0) begin
                jumpTag = tagBits'(22'h02b + 22'h0c9 * ($urandom % 8));
                addr = {jumpTag, indexBits'($urandom % numSets), 2'($urandom % 4), 2'b00};
            end else begin
                addr = {addr[31:3], 3'b000} + 32'd8;
            end
            fetchAddr[i] = addr;
        end
    endtask

    initial begin
        void'($urandom(32'hd576d1ff));
        makeFetches();
        rst = 1'b1;
        pc = fetchAddr[0];
        memRespValid = 1'b0;
        memRespLine = '0;
        srcIdx = 0;
        pairsDone = 0;
        phase = phRestart;
        modelPc = '0;
        respAddr = '0;
        respDelay = 0;
        accepted = 1'b0;
        respBusy = 1'b0;
        for (int s = 0; s < numSets; s++) begin
            refValid[s] = '0;
            refAge[s] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (pairsDone < numFetches) begin
            #1;
            stepModel();
            @(negedge clk);
            driveInputs();
        end
        if (protocolFailures() == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("one or more protocol assertions failed");
            $display("Done: errors found");
            $fatal(1, "assertion failures");
        end
    end

endmodule

// File: bench/iCacheTop_sva.sv
`timescale 1ns/1ps

module iCacheTop_sva (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic memReqValid,
    input logic [icachePkg::addrBits-1:0] memReqAddr,
    input logic memRespValid,
    input logic inst0Valid,
    input logic inst1Valid
);
    int reqStallFails = 0;
    int addrStableFails = 0;
    int resetValidFails = 0;
    int earlyPairFails = 0;

    // a pending line request always holds the fetch
    reqHoldsStall: assert property (@(posedge clk) disable iff (rst)
        memReqValid |-> stall)
        else begin
            reqStallFails++;
            $error("memReqValid high while stall is low");
        end

    reqAddrStable: assert property (@(posedge clk) disable iff (rst)
        (memReqValid ##1 memReqValid) |-> $stable(memReqAddr))
        else begin
            addrStableFails++;
            $error("memReqAddr changed during a request");
        end

    // the first cycle out of reset is a restart with nothing to deliver
    quietAfterReset: assert property (@(posedge clk)
        $fell(rst) |-> (!inst0Valid && !inst1Valid))
        else begin
            resetValidFails++;
            $error("output valid in the cycle after reset");
        end

    noPairBeforeResp: assert property (@(posedge clk) disable iff (rst)
        (memReqValid && !memRespValid) |-> !inst1Valid)
        else begin
            earlyPairFails++;
            $error("pair delivered while waiting for memory");
        end

endmodule

bind iCacheTop iCacheTop_sva u_iCacheTopSva (.*);

// File: files.f
hw/icachePkg.sv
hw/wayIf.sv
hw/wayStore.sv
hw/hitLookup.sv
hw/replacePolicy.sv
hw/fetchControl.sv
hw/iCacheTop.sv
bench/iCacheTop_sva.sv
bench/iCacheTb.sv

// File: hw/fetchControl.sv
`timescale 1ns/1ps

module fetchControl (
    input logic clk,
    input logic rst,
    input logic [icachePkg::addrBits-1:0] pc,
    wayIf.ctrl ways [icachePkg::numWays],
    input logic hit,
    input logic [icachePkg::wayBits-1:0] hitWay,
    input icachePkg::cacheLineT hitLine,
    input logic [icachePkg::wayBits-1:0] victimWay,
    output logic [icachePkg::indexBits-1:0] setIndex,
    output logic [icachePkg::tagBits-1:0] lookupTag,
    output logic touch,
    output logic [icachePkg::wayBits-1:0] touchWay,
    output logic fill,
    output logic stall,
    output logic memReqValid,
    output logic [icachePkg::addrBits-1:0] memReqAddr,
    input logic memRespValid,
    input icachePkg::cacheLineT memRespLine,
    output logic [icachePkg::addrBits-1:0] outPc,
    output logic inst0Valid,
    output logic [icachePkg::addrBits-1:0] inst0,
    output logic inst1Valid,
    output logic [icachePkg::addrBits-1:0] inst1
);
    import icachePkg::*;

    typedef enum logic [1:0] {
        stRestart,
        stLookup,
        stRefill
    } fetchStateT;

    fetchStateT state;
    fetchStateT nextState;
    logic [addrBits-1:0] heldPc;
    logic [indexBits-1:0] ramIndex;
    logic missNow;
    logic deliver;
    cacheLineT pairLine;

    assign setIndex = heldPc[offsetBits +: indexBits];
    assign lookupTag = heldPc[addrBits-1 -: tagBits];

    assign missNow = (state == stLookup) && !hit;

    // the request is held from the miss cycle through the response cycle
    assign stall = missNow || (state == stRefill);
    assign memReqValid = stall;
    assign memReqAddr = {heldPc[addrBits-1:offsetBits], {offsetBits{1'b0}}};

    assign fill = (state == stRefill) && memRespValid;
    assign touch = (state == stLookup) && hit;
    assign touchWay = fill ? victimWay : hitWay;

    // refill writes go to the held set, otherwise read ahead for the next pc
    assign ramIndex = (state == stRefill) ? setIndex : pc[offsetBits +: indexBits];

    for (genvar w = 0; w < numWays; w++) begin : gWayCtrl
        assign ways[w].writeEn = fill && (victimWay == wayBits'(w));
        assign ways[w].index = ramIndex;
        assign ways[w].tagIn = lookupTag;
        assign ways[w].lineIn = memRespLine;
    end

    always_comb begin
        nextState = state;
        case (state)
            stRestart: begin
                nextState = stLookup;
            end
            stLookup: begin
                if (!hit) begin
                    nextState = stRefill;
                end
            end
            stRefill: begin
                if (memRespValid) begin
                    nextState = stRestart;
                end
            end
            default: begin
                nextState = stRestart;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stRestart;
        end else begin
            state <= nextState;
        end
    end

    // every edge with stall low accepts the presented pc
    always_ff @(posedge clk) begin
        if (!stall) begin
            heldPc <= pc;
        end
    end

    // response line is forwarded in the cycle it arrives
    assign deliver = touch || fill;
    assign pairLine = (state == stRefill) ? memRespLine : hitLine;

    assign outPc = {heldPc[addrBits-1:3], 3'b000};
    assign inst0 = pairLine.words[{heldPc[3], 1'b0}];
    assign inst1 = pairLine.words[{heldPc[3], 1'b1}];
    // odd word start means only the second slot carries an instruction
    assign inst0Valid = deliver && !heldPc[2];
    assign inst1Valid = deliver;

endmodule

// File: hw/hitLookup.sv
`timescale 1ns/1ps

module hitLookup (
    wayIf.lookup ways [icachePkg::numWays],
    input logic [icachePkg::tagBits-1:0] lookupTag,
    input logic [icachePkg::numWays-1:0] validMask,
    output logic hit,
    output logic [icachePkg::wayBits-1:0] hitWay,
    output icachePkg::cacheLineT hitLine
);
    import icachePkg::*;

    logic [numWays-1:0] match;
    cacheLineT storedLine [numWays];

    for (genvar w = 0; w < numWays; w++) begin : gWay
        // an invalid way never hits, whatever its tag RAM holds
        assign match[w] = validMask[w] && (ways[w].tagOut == lookupTag);
        assign storedLine[w] = ways[w].lineOut;
    end

    assign hit = |match;

    // lowest matching way wins
    always_comb begin
        hitWay = '0;
        hitLine = storedLine[0];
        for (int w = numWays - 1; w >= 0; w--) begin
            if (match[w]) begin
                hitWay = wayBits'(w);
                hitLine = storedLine[w];
            end
        end
    end

endmodule

// File: hw/iCacheTop.sv
`timescale 1ns/1ps

module iCacheTop (
    input logic clk,
    input logic rst,
    input logic [icachePkg::addrBits-1:0] pc,
    output logic stall,
    output logic memReqValid,
    output logic [icachePkg::addrBits-1:0] memReqAddr,
    input logic memRespValid,
    input icachePkg::cacheLineT memRespLine,
    output logic [icachePkg::addrBits-1:0] outPc,
    output logic inst0Valid,
    output logic [icachePkg::addrBits-1:0] inst0,
    output logic inst1Valid,
    output logic [icachePkg::addrBits-1:0] inst1
);
    import icachePkg::*;

    logic hit;
    logic [wayBits-1:0] hitWay;
    cacheLineT hitLine;
    logic [numWays-1:0] validMask;
    logic [wayBits-1:0] victimWay;
    logic [indexBits-1:0] setIndex;
    logic [tagBits-1:0] lookupTag;
    logic touch;
    logic [wayBits-1:0] touchWay;
    logic fill;

    wayIf wayBus [numWays] ();

    for (genvar w = 0; w < numWays; w++) begin : gWay
        wayStore u_wayStore (
            .clk (clk),
            .way (wayBus[w])
        );
    end

    hitLookup u_hitLookup (
        .ways      (wayBus),
        .lookupTag (lookupTag),
        .validMask (validMask),
        .hit       (hit),
        .hitWay    (hitWay),
        .hitLine   (hitLine)
    );

    replacePolicy u_replacePolicy (
        .clk       (clk),
        .rst       (rst),
        .setIndex  (setIndex),
        .touch     (touch),
        .touchWay  (touchWay),
        .fill      (fill),
        .validMask (validMask),
        .victimWay (victimWay)
    );

    fetchControl u_fetchControl (
        .clk          (clk),
        .rst          (rst),
        .pc           (pc),
        .ways         (wayBus),
        .hit          (hit),
        .hitWay       (hitWay),
        .hitLine      (hitLine),
        .victimWay    (victimWay),
        .setIndex     (setIndex),
        .lookupTag    (lookupTag),
        .touch        (touch),
        .touchWay     (touchWay),
        .fill         (fill),
        .stall        (stall),
        .memReqValid  (memReqValid),
        .memReqAddr   (memReqAddr),
        .memRespValid (memRespValid),
        .memRespLine  (memRespLine),
        .outPc        (outPc),
        .inst0Valid   (inst0Valid),
        .inst0        (inst0),
        .inst1Valid   (inst1Valid),
        .inst1        (inst1)
    );

endmodule

// File: hw/icachePkg.sv
package icachePkg;

    // cache geometry
    localparam int numWays = 4;
    localparam int wayBits = 2;
    localparam int numSets = 64;

    // tag in bits 31..10, set index in 9..4, byte offset in 3..0
    localparam int indexBits = 6;
    localparam int offsetBits = 4;
    localparam int tagBits = 22;

    localparam int lineBits = 128;
    localparam int addrBits = 32;

    // tree pseudo-LRU bits per set
    localparam int ageBits = 3;

    // one line seen either as raw storage or as four instruction words
    // word 0 sits in the low bits
    typedef union packed {
        logic [lineBits-1:0] raw;
        logic [3:0][addrBits-1:0] words;
    } cacheLineT;

endpackage

// File: hw/replacePolicy.sv
`timescale 1ns/1ps

module replacePolicy (
    input logic clk,
    input logic rst,
    input logic [icachePkg::indexBits-1:0] setIndex,
    input logic touch,
    input logic [icachePkg::wayBits-1:0] touchWay,
    input logic fill,
    output logic [icachePkg::numWays-1:0] validMask,
    output logic [icachePkg::wayBits-1:0] victimWay
);
    import icachePkg::*;

    logic [numWays-1:0] validBits [numSets];
    logic [ageBits-1:0] setAge [numSets];
    logic [ageBits-1:0] curAge;
    logic [ageBits-1:0] nextAge;
    logic [wayBits-1:0] freeWay;

    assign validMask = validBits[setIndex];
    assign curAge = setAge[setIndex];

    // bit 2 picks the half, bit 0 or bit 1 the way inside it
    always_comb begin
        nextAge = curAge;
        case (touchWay)
            2'd0: begin
                nextAge[2] = 1'b1;
                nextAge[0] = 1'b1;
            end
            2'd1: begin
                nextAge[2] = 1'b1;
                nextAge[0] = 1'b0;
            end
            2'd2: begin
                nextAge[2] = 1'b0;
                nextAge[1] = 1'b1;
            end
            default: begin
                nextAge[2] = 1'b0;
                nextAge[1] = 1'b0;
            end
        endcase
    end

    always_comb begin
        freeWay = '0;
        for (int w = numWays - 1; w >= 0; w--) begin
            if (!validMask[w]) begin
                freeWay = wayBits'(w);
            end
        end
    end

    // invalid ways are filled first
    always_comb begin
        if (!(&validMask)) begin
            victimWay = freeWay;
        end else if (curAge[2]) begin
            victimWay = {1'b1, curAge[1]};
        end else begin
            victimWay = {1'b0, curAge[0]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < numSets; s++) begin
                validBits[s] <= '0;
                setAge[s] <= '0;
            end
        end else begin
            if (fill) begin
                validBits[setIndex][touchWay] <= 1'b1;
            end
            if (touch || fill) begin
                setAge[setIndex] <= nextAge;
            end
        end
    end

endmodule

// File: hw/wayIf.sv
`timescale 1ns/1ps

interface wayIf;
    import icachePkg::*;

    logic writeEn;
    logic [indexBits-1:0] index;
    logic [tagBits-1:0] tagIn;
    cacheLineT lineIn;
    logic [tagBits-1:0] tagOut;
    cacheLineT lineOut;

    // controller drives the address and the refill data
    modport ctrl (
        output writeEn,
        output index,
        output tagIn,
        output lineIn
    );

    modport store (
        input writeEn,
        input index,
        input tagIn,
        input lineIn,
        output tagOut,
        output lineOut
    );

    modport lookup (
        input tagOut,
        input lineOut
    );

endinterface

// File: hw/wayStore.sv
`timescale 1ns/1ps

module wayStore (
    input logic clk,
    wayIf.store way
);
    import icachePkg::*;

    logic [tagBits-1:0] tagMem [numSets];
    logic [lineBits-1:0] lineMem [numSets];

    // tag and line are always written as a pair
    always_ff @(posedge clk) begin
        if (way.writeEn) begin
            tagMem[way.index] <= way.tagIn;
            lineMem[way.index] <= way.lineIn.raw;
        end
    end

    // synchronous read returns old contents on a same-index write
    always_ff @(posedge clk) begin
        way.tagOut <= tagMem[way.index];
        way.lineOut.raw <= lineMem[way.index];
    end

endmodule
